// ==== Makefile ====
# Verilator simulation of the multi-cycle CPU
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
src/cpu_pkg.sv
src/inst_decoder.sv
src/cpu_fsm.sv
src/regfile.sv
src/alu.sv
src/cpu_datapath.sv
src/mycpu_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] alu_src1,
    input  logic [xlen-1:0] alu_src2,
    output logic [xlen-1:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];  // shifts use the low five bits only

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = alu_src1 + alu_src2;
            end
            alu_sub: begin
                alu_result = alu_src1 - alu_src2;
            end
            alu_slt: begin
                alu_result = {{(xlen-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
            end
            alu_sltu: begin
                alu_result = {{(xlen-1){1'b0}}, alu_src1 < alu_src2};
            end
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_sll:  alu_result = alu_src1 << shamt;
            alu_srl:  alu_result = alu_src1 >> shamt;
            alu_sra: begin
                alu_result = $signed(alu_src1) >>> shamt;
            end
            alu_lui:  alu_result = alu_src2;  // immediate already shifted by the decoder
            default:  alu_result = '0;
        endcase
    end

endmodule

// ==== src/cpu_datapath.sv ====
`timescale 1ns/1ps

module cpu_datapath import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_state_t            state,
    input  logic                  src1_is_pc,
    input  logic                  src2_is_imm,
    input  logic                  src_reg_is_rd,
    input  logic [xlen-1:0]       imm,
    input  logic [xlen-1:0]       br_offs,
    input  logic                  is_beq,
    input  logic                  is_bne,
    input  logic                  is_jirl,
    input  logic                  is_jump,
    input  logic                  mem_we,
    input  logic                  res_from_mem,
    input  logic                  gr_we,
    input  logic [reg_addr_w-1:0] dest,
    input  logic [reg_addr_w-1:0] rj,
    input  logic [reg_addr_w-1:0] rk,
    input  logic [reg_addr_w-1:0] rd,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    input  logic [xlen-1:0]       alu_result,
    input  logic [xlen-1:0]       inst_sram_rdata,
    input  logic [xlen-1:0]       data_sram_rdata,
    output logic [xlen-1:0]       inst,
    output logic [reg_addr_w-1:0] rf_raddr1,
    output logic [reg_addr_w-1:0] rf_raddr2,
    output logic                  rf_we,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic [xlen-1:0]       rf_wdata,
    output logic [xlen-1:0]       alu_src1,
    output logic [xlen-1:0]       alu_src2,
    output logic [xlen-1:0]       inst_sram_addr,
    output logic                  data_sram_we,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    logic [xlen-1:0] pc;          // next fetch address once decode is done
    logic [xlen-1:0] inst_pc;     // pc of the instruction in flight
    logic [xlen-1:0] inst_q;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
    logic [xlen-1:0] alu_res_q;
    logic [xlen-1:0] mem_result;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] br_target;
    logic            rj_eq_rd;
    logic            br_taken;

    // the sram word is only valid in decode, later states use the captured copy
    assign inst           = (state == st_decode) ? inst_sram_rdata : inst_q;
    assign inst_sram_addr = pc;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = src_reg_is_rd ? rd : rk;

    // **************************************************
    // branch resolution in decode
    // **************************************************

    assign seq_pc    = pc + xlen'(4);
    assign rj_eq_rd  = (rf_rdata1 == rf_rdata2);
    assign br_taken  = is_jump || is_jirl || (is_beq && rj_eq_rd) || (is_bne && !rj_eq_rd);
    assign br_target = (is_jirl ? rf_rdata1 : pc) + br_offs;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (state == st_decode) begin
            pc <= br_taken ? br_target : seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            inst_q    <= inst_sram_rdata;
            inst_pc   <= pc;
            rj_value  <= rf_rdata1;
            rkd_value <= rf_rdata2;
        end
        if (state == st_execute) begin
            alu_res_q <= alu_result;
        end
        if (state == st_memory) begin
            mem_result <= data_sram_rdata;
        end
    end

    assign alu_src1 = src1_is_pc ? inst_pc : rj_value;  // pc + 4 for the link
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    assign data_sram_we    = (state == st_execute) && mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;

    assign rf_we    = (state == st_writeback) && gr_we;
    assign rf_waddr = dest;
    assign rf_wdata = res_from_mem ? mem_result : alu_res_q;

    assign debug_wb_pc       = inst_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== src/cpu_fsm.sv ====
`timescale 1ns/1ps

module cpu_fsm import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       is_branch_only,
    input  logic       is_mem,
    input  logic       is_load,
    output cpu_state_t state
);

    cpu_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    // **************************************************
    // next state, one cycle per state
    // **************************************************

    always_comb begin
        case (state)
            st_fetch: begin
                next_state = st_decode;
            end
            st_decode: begin
                // branches finish once the pc is updated
                next_state = is_branch_only ? st_fetch : st_execute;
            end
            st_execute: begin
                next_state = is_mem ? st_memory : st_writeback;
            end
            st_memory: begin
                next_state = is_load ? st_writeback : st_fetch;  // a store ends here
            end
            st_writeback: begin
                next_state = st_fetch;
            end
            default: begin
                next_state = st_fetch;  // recover from unused encodings
            end
        endcase
    end

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // **************************************************
    // widths and reset values
    // **************************************************

    localparam int xlen       = 32;  // data and address width
    localparam int reg_addr_w = 5;   // register number width
    localparam int num_regs   = 2 ** reg_addr_w;

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;  // first fetch address

    // **************************************************
    // control state encoding
    // **************************************************

    typedef enum logic [2:0] {
        st_fetch     = 3'd0,  // instruction address on the inst sram
        st_decode    = 3'd1,  // instruction word arrives, operands read, pc updated
        st_execute   = 3'd2,  // alu works, data sram strobed
        st_memory    = 3'd3,  // load data arrives
        st_writeback = 3'd4   // register file written and traced
    } cpu_state_t;

    // **************************************************
    // alu operation encoding
    // **************************************************

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11   // passes the second operand through
    } alu_op_t;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import cpu_pkg::*; (
    input  logic [xlen-1:0]       inst,
    output alu_op_t               alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic                  src_reg_is_rd,
    output logic [xlen-1:0]       imm,
    output logic [xlen-1:0]       br_offs,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  is_jirl,
    output logic                  is_jump,
    output logic                  is_branch_only,
    output logic                  is_mem,
    output logic                  is_load,
    output logic                  mem_we,
    output logic                  res_from_mem,
    output logic                  gr_we,
    output logic [reg_addr_w-1:0] dest,
    output logic [reg_addr_w-1:0] rj,
    output logic [reg_addr_w-1:0] rk,
    output logic [reg_addr_w-1:0] rd
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        op_3r;
    logic        op_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};  // offs[15:0] sits above offs[25:16]

    assign op_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign op_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = op_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = op_3r && (op_19_15 == 5'h02);
    assign inst_slt     = op_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = op_3r && (op_19_15 == 5'h05);
    assign inst_nor     = op_3r && (op_19_15 == 5'h08);
    assign inst_and     = op_3r && (op_19_15 == 5'h09);
    assign inst_or      = op_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = op_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = op_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = op_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = op_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign is_beq       = (op_31_26 == 6'h16);
    assign is_bne       = (op_31_26 == 6'h17);

    always_comb begin
        alu_op = alu_add;  // loads, stores and links all add
        if (inst_sub_w)   alu_op = alu_sub;
        if (inst_slt)     alu_op = alu_slt;
        if (inst_sltu)    alu_op = alu_sltu;
        if (inst_and)     alu_op = alu_and;
        if (inst_nor)     alu_op = alu_nor;
        if (inst_or)      alu_op = alu_or;
        if (inst_xor)     alu_op = alu_xor;
        if (inst_slli_w)  alu_op = alu_sll;
        if (inst_srli_w)  alu_op = alu_srl;
        if (inst_srai_w)  alu_op = alu_sra;
        if (inst_lu12i_w) alu_op = alu_lui;
    end

    // the link value is pc + 4, so jirl and bl take the constant 4 as immediate
    assign imm = (inst_jirl || inst_bl) ? xlen'(4) :
                 inst_lu12i_w          ? {i20, 12'b0} :
                                         {{20{i12[11]}}, i12};

    assign br_offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                           {{14{i16[15]}}, i16, 2'b0};

    assign is_jirl        = inst_jirl;
    assign is_jump        = inst_b || inst_bl;
    assign is_branch_only = inst_b || is_beq || is_bne;
    assign is_mem         = inst_ld_w || inst_st_w;
    assign is_load        = inst_ld_w;
    assign mem_we         = inst_st_w;
    assign res_from_mem   = inst_ld_w;
    assign src1_is_pc     = inst_jirl || inst_bl;
    assign src_reg_is_rd  = is_beq || is_bne || inst_st_w;
    assign src2_is_imm    = inst_slli_w || inst_srli_w || inst_srai_w || inst_addi_w
                          || inst_ld_w || inst_st_w || inst_lu12i_w || inst_jirl || inst_bl;

    // unknown encodings match none of these and retire without a write
    assign gr_we = inst_add_w || inst_sub_w || inst_slt || inst_sltu || inst_nor
                 || inst_and || inst_or || inst_xor || inst_slli_w || inst_srli_w
                 || inst_srai_w || inst_addi_w || inst_lu12i_w || inst_ld_w
                 || inst_jirl || inst_bl;
    assign dest  = inst_bl ? reg_addr_w'(1) : rd;

endmodule

// ==== src/mycpu_top.sv ====
`timescale 1ns/1ps

module mycpu_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  inst_sram_we,
    output logic [xlen-1:0]       inst_sram_addr,
    output logic [xlen-1:0]       inst_sram_wdata,
    input  logic [xlen-1:0]       inst_sram_rdata,
    output logic                  data_sram_we,
    output logic [xlen-1:0]       data_sram_addr,
    output logic [xlen-1:0]       data_sram_wdata,
    input  logic [xlen-1:0]       data_sram_rdata,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_we,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata
);

    cpu_state_t            state;
    alu_op_t               alu_op;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       br_offs;
    logic                  src1_is_pc, src2_is_imm, src_reg_is_rd;
    logic                  is_beq, is_bne, is_jirl, is_jump;
    logic                  is_branch_only, is_mem, is_load;
    logic                  mem_we, res_from_mem, gr_we;
    logic [reg_addr_w-1:0] dest, rj, rk, rd;
    logic [reg_addr_w-1:0] rf_raddr1, rf_raddr2, rf_waddr;
    logic [xlen-1:0]       rf_rdata1, rf_rdata2, rf_wdata;
    logic                  rf_we;
    logic [xlen-1:0]       alu_src1, alu_src2, alu_result;

    assign inst_sram_we    = 1'b0;  // instruction memory is read only
    assign inst_sram_wdata = '0;

    cpu_fsm u_fsm (
        .clk(clk), .reset(reset), .is_branch_only(is_branch_only),
        .is_mem(is_mem), .is_load(is_load), .state(state)
    );

    inst_decoder u_decoder (
        .inst(inst), .alu_op(alu_op), .src1_is_pc(src1_is_pc), .src2_is_imm(src2_is_imm),
        .src_reg_is_rd(src_reg_is_rd), .imm(imm), .br_offs(br_offs), .is_beq(is_beq),
        .is_bne(is_bne), .is_jirl(is_jirl), .is_jump(is_jump),
        .is_branch_only(is_branch_only), .is_mem(is_mem), .is_load(is_load),
        .mem_we(mem_we), .res_from_mem(res_from_mem), .gr_we(gr_we), .dest(dest),
        .rj(rj), .rk(rk), .rd(rd)
    );

    regfile u_regfile (
        .clk(clk), .raddr1(rf_raddr1), .raddr2(rf_raddr2), .we(rf_we),
        .waddr(rf_waddr), .wdata(rf_wdata), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    alu u_alu (
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2), .alu_result(alu_result)
    );

    cpu_datapath u_datapath (
        .clk(clk), .reset(reset), .state(state), .src1_is_pc(src1_is_pc),
        .src2_is_imm(src2_is_imm), .src_reg_is_rd(src_reg_is_rd), .imm(imm),
        .br_offs(br_offs), .is_beq(is_beq), .is_bne(is_bne), .is_jirl(is_jirl),
        .is_jump(is_jump), .mem_we(mem_we), .res_from_mem(res_from_mem), .gr_we(gr_we),
        .dest(dest), .rj(rj), .rk(rk), .rd(rd), .rf_rdata1(rf_rdata1),
        .rf_rdata2(rf_rdata2), .alu_result(alu_result), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_rdata(data_sram_rdata), .inst(inst), .rf_raddr1(rf_raddr1),
        .rf_raddr2(rf_raddr2), .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .alu_src1(alu_src1), .alu_src2(alu_src2), .inst_sram_addr(inst_sram_addr),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;  // writes to r0 are dropped
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; #(
    parameter int n_rows = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [xlen-1:0]       debug_wb_pc,
    input  logic [3:0]            debug_wb_rf_we,
    input  logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    input  logic [xlen-1:0]       debug_wb_rf_wdata,
    input  logic                  inst_sram_we,
    input  logic [xlen-1:0]       inst_sram_wdata,
    input  logic                  data_sram_we,
    input  int                    exp_test [n_rows],
    input  logic [xlen-1:0]       exp_pc [n_rows],
    input  logic [reg_addr_w-1:0] exp_num [n_rows],
    input  logic [xlen-1:0]       exp_val [n_rows],
    output int                    rows_seen,
    output int                    error_count,
    output int                    tests_passed,
    output int                    tests_failed
);

    int   seen       = 0;
    int   err_count  = 0;
    int   pass_count = 0;
    int   fail_count = 0;
    int   test_errs  = 0;     // wrong values within the current test
    logic reset_q    = 1'b1;  // reset as it was one cycle earlier

    assign rows_seen    = seen;
    assign error_count  = err_count;
    assign tests_passed = pass_count;
    assign tests_failed = fail_count;

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic compare_row(input int row);
        logic last_of_test;
        check_value("debug_wb_rf_we", xlen'(debug_wb_rf_we), xlen'(4'hf));
        check_value("debug_wb_pc", debug_wb_pc, exp_pc[row]);
        check_value("debug_wb_rf_wnum", xlen'(debug_wb_rf_wnum), xlen'(exp_num[row]));
        check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_val[row]);
        last_of_test = (row == n_rows - 1) || (exp_test[row + 1] != exp_test[row]);
        if (last_of_test) begin
            if (test_errs == 0) begin
                $display("test %0d passed", exp_test[row]);
                pass_count++;
            end else begin
                $display("test %0d failed with %0d wrong values", exp_test[row], test_errs);
                fail_count++;
            end
            test_errs = 0;
        end
    endtask

    // **************************************************
    // trace sampled mid-cycle, away from the clock edge
    // **************************************************

    always @(negedge clk) begin
        if (debug_wb_rf_we != 4'b0000) begin
            if (reset || reset_q) begin
                $display("at %0t a register write showed up on the trace during or just after reset",
                         $time);
                err_count++;
            end else if (seen >= n_rows) begin
                $display("at %0t extra write to r%0d from pc %h after all %0d expected writes",
                         $time, debug_wb_rf_wnum, debug_wb_pc, n_rows);
                err_count++;
            end else begin
                compare_row(seen);
                seen++;
            end
        end
    end

    // **************************************************
    // sram strobes
    // **************************************************

    always @(negedge clk) begin
        check_value("inst_sram_we", xlen'(inst_sram_we), '0);  // inst sram is read only
        check_value("inst_sram_wdata", inst_sram_wdata, '0);
        if (reset || reset_q) begin
            check_value("data_sram_we", xlen'(data_sram_we), '0);  // no store around reset
        end
        reset_q <= reset;
    end

endmodule

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

    localparam int n_prog       = 41;
    localparam int n_exp        = 29;
    localparam int mem_words    = 64;
    localparam int cycle_limit  = 5 * n_prog + 50;
    localparam int drain_cycles = 10;
    localparam logic [xlen-1:0] end_pc = reset_pc + xlen'(4 * (n_prog - 1));

    logic                  clk;
    logic                  reset = 1'b1;
    logic                  inst_sram_we;
    logic [xlen-1:0]       inst_sram_addr;
    logic [xlen-1:0]       inst_sram_wdata;
    logic [xlen-1:0]       inst_sram_rdata = '0;
    logic                  data_sram_we;
    logic [xlen-1:0]       data_sram_addr;
    logic [xlen-1:0]       data_sram_wdata;
    logic [xlen-1:0]       data_sram_rdata = '0;
    logic [xlen-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_we;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]       debug_wb_rf_wdata;

    logic [xlen-1:0]       prog [n_prog];
    int                    exp_test [n_exp];
    logic [xlen-1:0]       exp_pc [n_exp];
    logic [reg_addr_w-1:0] exp_num [n_exp];
    logic [xlen-1:0]       exp_val [n_exp];
    int                    exp_fill = 0;
    logic [xlen-1:0]       imem [mem_words];
    logic [xlen-1:0]       dmem [mem_words] = '{default: '0};
    logic [xlen-1:0]       iaddr_q, daddr_q, dwdata_q;
    logic                  dwe_q;
    int                    cycles = 0;
    int                    rows_seen, error_count, tests_passed, tests_failed;
    bit                    run_failed = 1'b0;

    mycpu_top UUT (
        .clk(clk), .reset(reset), .inst_sram_we(inst_sram_we),
        .inst_sram_addr(inst_sram_addr), .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    tb_checker #(.n_rows(n_exp)) trace_check (
        .clk(clk), .reset(reset), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata), .inst_sram_we(inst_sram_we),
        .inst_sram_wdata(inst_sram_wdata), .data_sram_we(data_sram_we),
        .exp_test(exp_test), .exp_pc(exp_pc),
        .exp_num(exp_num), .exp_val(exp_val), .rows_seen(rows_seen),
        .error_count(error_count), .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // **************************************************
    // sram models, one cycle from address to data
    // **************************************************

    always @(negedge clk) begin
        iaddr_q  <= inst_sram_addr;  // addresses and strobes are settled by now
        daddr_q  <= data_sram_addr;
        dwdata_q <= data_sram_wdata;
        dwe_q    <= data_sram_we;
    end

    always @(posedge clk) begin
        #1;
        inst_sram_rdata = imem[iaddr_q[7:2]];
        if (dwe_q) begin
            dmem[daddr_q[7:2]] = dwdata_q;  // the store lands at the end of execute
        end
        data_sram_rdata = dmem[daddr_q[7:2]];
    end

    // **************************************************
    // instruction encoders and the tables
    // **************************************************

    function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};  // also the ui5 shifts, with ui5 in the rk field
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] si12);
        return {op, si12, rj, rd};
    endfunction

    function automatic logic [31:0] ri16_word(input logic [5:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] i26_word(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] lu12i_word(input logic [4:0] rd, input logic [19:0] si20);
        return {7'b0001010, si20, rd};
    endfunction

    function automatic logic [xlen-1:0] pc_at(input int index);
        return reset_pc + xlen'(4 * index);
    endfunction

    task automatic add_expect(input int test, input int index,
                              input logic [reg_addr_w-1:0] num, input logic [xlen-1:0] value);
        exp_test[exp_fill] = test;
        exp_pc[exp_fill]   = pc_at(index);
        exp_num[exp_fill]  = num;
        exp_val[exp_fill]  = value;
        exp_fill++;
    endtask

    task automatic fill_tables();
        prog[0]  = ri12_word(10'h00a, 5'd1, 5'd0, 12'd5);       // addi.w r1, r0, 5
        prog[1]  = ri12_word(10'h00a, 5'd0, 5'd0, 12'd7);       // addi.w r0, r0, 7
        prog[2]  = r3_word(17'h00020, 5'd2, 5'd0, 5'd1);        // add.w r2, r0, r1
        prog[3]  = ri12_word(10'h00a, 5'd3, 5'd0, 12'hffd);     // addi.w r3, r0, -3
        prog[4]  = ri12_word(10'h00a, 5'd4, 5'd0, 12'd6);       // addi.w r4, r0, 6
        prog[5]  = r3_word(17'h00020, 5'd5, 5'd3, 5'd4);        // add.w r5, r3, r4
        prog[6]  = r3_word(17'h00022, 5'd6, 5'd4, 5'd3);        // sub.w r6, r4, r3
        prog[7]  = r3_word(17'h00024, 5'd7, 5'd3, 5'd4);        // slt r7, r3, r4
        prog[8]  = r3_word(17'h00025, 5'd8, 5'd3, 5'd4);        // sltu r8, r3, r4
        prog[9]  = r3_word(17'h00028, 5'd9, 5'd4, 5'd1);        // nor r9, r4, r1
        prog[10] = r3_word(17'h00029, 5'd10, 5'd3, 5'd4);       // and r10, r3, r4
        prog[11] = r3_word(17'h0002a, 5'd11, 5'd4, 5'd1);       // or r11, r4, r1
        prog[12] = r3_word(17'h0002b, 5'd12, 5'd3, 5'd4);       // xor r12, r3, r4
        prog[13] = ri12_word(10'h00a, 5'd13, 5'd3, 12'h800);    // addi.w r13, r3, -2048
        prog[14] = r3_word(17'h00081, 5'd14, 5'd3, 5'd4);       // slli.w r14, r3, 4
        prog[15] = r3_word(17'h00089, 5'd15, 5'd3, 5'd4);       // srli.w r15, r3, 4
        prog[16] = r3_word(17'h00091, 5'd16, 5'd3, 5'd1);       // srai.w r16, r3, 1
        prog[17] = lu12i_word(5'd17, 20'h80123);                // lu12i.w r17, 0x80123
        prog[18] = ri12_word(10'h00a, 5'd18, 5'd0, 12'h040);    // addi.w r18, r0, 0x40
        prog[19] = ri12_word(10'h0a6, 5'd17, 5'd18, 12'd0);     // st.w r17, r18, 0
        prog[20] = ri12_word(10'h0a6, 5'd13, 5'd18, 12'd4);     // st.w r13, r18, 4
        prog[21] = ri12_word(10'h0a2, 5'd19, 5'd0, 12'h040);    // ld.w r19, r0, 0x40
        prog[22] = ri12_word(10'h0a2, 5'd20, 5'd18, 12'd4);     // ld.w r20, r18, 4
        prog[23] = ri16_word(6'h16, 5'd2, 5'd1, 16'd2);         // beq r1, r2 taken
        prog[24] = ri12_word(10'h00a, 5'd21, 5'd0, 12'd1);      // skipped
        prog[25] = ri12_word(10'h00a, 5'd21, 5'd0, 12'd2);
        prog[26] = ri16_word(6'h16, 5'd4, 5'd1, 16'd2);         // beq r1, r4 falls through
        prog[27] = ri12_word(10'h00a, 5'd22, 5'd0, 12'd3);
        prog[28] = ri16_word(6'h17, 5'd4, 5'd1, 16'd2);         // bne r1, r4 taken
        prog[29] = ri12_word(10'h00a, 5'd23, 5'd0, 12'd4);      // skipped
        prog[30] = ri16_word(6'h17, 5'd2, 5'd1, 16'd2);         // bne r1, r2 falls through
        prog[31] = ri12_word(10'h00a, 5'd23, 5'd0, 12'd5);
        prog[32] = i26_word(6'h14, 26'd2);                      // b over the next one
        prog[33] = ri12_word(10'h00a, 5'd24, 5'd0, 12'd6);      // skipped
        prog[34] = ri12_word(10'h00a, 5'd24, 5'd0, 12'd7);
        prog[35] = i26_word(6'h15, 26'd3);                      // bl to prog[38]
        prog[36] = ri12_word(10'h00a, 5'd25, 5'd0, 12'd9);      // runs after the return
        prog[37] = i26_word(6'h14, 26'd3);                      // b to the final loop
        prog[38] = ri12_word(10'h00a, 5'd26, 5'd0, 12'd8);
        prog[39] = ri16_word(6'h13, 5'd27, 5'd1, 16'd0);        // jirl r27, r1, 0
        prog[40] = i26_word(6'h14, 26'd0);                      // b to itself, end of program

        add_expect(1, 0, 5'd1, 32'd5);
        add_expect(1, 1, 5'd0, 32'd7);  // r0 write is traced but not kept
        add_expect(1, 2, 5'd2, 32'd5);
        add_expect(2, 3, 5'd3, 32'hffff_fffd);
        add_expect(2, 4, 5'd4, 32'd6);
        add_expect(2, 5, 5'd5, 32'd3);
        add_expect(2, 6, 5'd6, 32'd9);
        add_expect(2, 7, 5'd7, 32'd1);  // -3 < 6 signed
        add_expect(2, 8, 5'd8, 32'd0);  // but not unsigned
        add_expect(2, 9, 5'd9, 32'hffff_fff8);
        add_expect(2, 10, 5'd10, 32'd4);
        add_expect(2, 11, 5'd11, 32'd7);
        add_expect(2, 12, 5'd12, 32'hffff_fffb);
        add_expect(3, 13, 5'd13, 32'hffff_f7fd);
        add_expect(3, 14, 5'd14, 32'hffff_ffd0);
        add_expect(3, 15, 5'd15, 32'h0fff_ffff);
        add_expect(3, 16, 5'd16, 32'hffff_fffe);
        add_expect(3, 17, 5'd17, 32'h8012_3000);
        add_expect(4, 18, 5'd18, 32'h0000_0040);
        add_expect(4, 21, 5'd19, 32'h8012_3000);
        add_expect(4, 22, 5'd20, 32'hffff_f7fd);
        add_expect(5, 25, 5'd21, 32'd2);
        add_expect(5, 27, 5'd22, 32'd3);
        add_expect(5, 31, 5'd23, 32'd5);
        add_expect(5, 34, 5'd24, 32'd7);
        add_expect(6, 35, 5'd1, pc_at(36));
        add_expect(6, 38, 5'd26, 32'd8);
        add_expect(6, 39, 5'd27, pc_at(40));
        add_expect(6, 36, 5'd25, 32'd9);
    endtask

    // **************************************************
    // run
    // **************************************************

    initial begin
        fill_tables();
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = (i < n_prog) ? prog[i] : '0;  // word 0 sits at reset_pc
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        while (inst_sram_addr !== end_pc && cycles < cycle_limit) begin
            @(negedge clk);
        end
        if (inst_sram_addr !== end_pc) begin
            $display("timeout: the program did not reach its final loop within %0d cycles",
                     cycle_limit);
            run_failed = 1'b1;
        end else begin
            repeat (drain_cycles) @(negedge clk);  // a stray write would show up here
        end
        if (rows_seen < n_exp) begin
            $display("missing writes: only %0d of %0d expected register writes were seen",
                     rows_seen, n_exp);
            run_failed = 1'b1;
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (run_failed || error_count != 0 || tests_failed != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule
